// ==== rvv_backend_alu.f ====
hdl/rvv_backend_pkg.sv
hdl/rvv_backend_alu_rs.sv
hdl/rvv_backend_alu_unit.sv
hdl/rvv_backend_alu.sv
tb/rvv_backend_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ALU path testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=rvv_backend_alu_tb
log=sim.log

rm -rf obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module "$top" \
  -f rvv_backend_alu.f \
  -o "$top"
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TB PASSED$" "$log"; then
  echo "run_sim: simulation passed"
  exit 0
fi
echo "run_sim: pass line not found in $log"
exit 1

// ==== tb/rvv_backend_alu_tb.sv ====
`timescale 1ns/1ps

module rvv_backend_alu_tb
  import rvv_backend_pkg::*;
;

  localparam int vlen            = 128;
  localparam int rob_depth_width = 3;
  localparam int rs_depth        = 4;
  localparam int vstart_width    = $clog2(vlen);
  localparam int timeout_cycles  = 50;
  localparam opm_funct6_e op_list [8] = '{VMANDN, VMAND, VMOR, VMXOR,
                                          VMORN, VMNAND, VMNOR, VMXNOR};

  logic                       clk = 1'b0;
  logic                       reset;
  logic                       uop_valid;
  logic                       rs_full;
  logic [rob_depth_width-1:0] uop_rob_entry;
  exe_funct3_e                uop_funct3;
  logic [5:0]                 uop_funct6;
  logic [vstart_width-1:0]    uop_vstart;
  logic                       uop_vm;
  logic [vlen-1:0]            uop_vd_data;
  logic                       uop_vd_valid;
  logic [vlen-1:0]            uop_vs1_data;
  logic                       uop_vs1_valid;
  logic [vlen-1:0]            uop_vs2_data;
  logic                       uop_vs2_valid;
  logic                       result_valid;
  logic [rob_depth_width-1:0] result_rob_entry;
  logic [vlen-1:0]            result_data;

  // reference model state
  logic [rob_depth_width-1:0] exp_rob [$];
  logic [vlen-1:0]            exp_data [$];
  logic [rob_depth_width-1:0] head_rob;
  logic [vlen-1:0]            head_data;
  int                         outstanding;
  int                         uops_sent;
  int                         results_seen;

  always #5 clk = ~clk;

  rvv_backend_alu #(
    .vlen            (vlen),
    .rob_depth_width (rob_depth_width),
    .rs_depth        (rs_depth)
  ) dut0 (
    .clk              (clk),
    .reset            (reset),
    .uop_valid        (uop_valid),
    .rs_full          (rs_full),
    .uop_rob_entry    (uop_rob_entry),
    .uop_funct3       (uop_funct3),
    .uop_funct6       (uop_funct6),
    .uop_vstart       (uop_vstart),
    .uop_vm           (uop_vm),
    .uop_vd_data      (uop_vd_data),
    .uop_vd_valid     (uop_vd_valid),
    .uop_vs1_data     (uop_vs1_data),
    .uop_vs1_valid    (uop_vs1_valid),
    .uop_vs2_data     (uop_vs2_data),
    .uop_vs2_valid    (uop_vs2_valid),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  task automatic end_in_failure();
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic value_mismatch(input string name, input logic [vlen-1:0] expected,
                                input logic [vlen-1:0] actual);
    $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end_in_failure();
  endtask

  task automatic run_failed(input string what);
    $display("** Error at %0t: %s", $time, what);
    end_in_failure();
  endtask

  // one bit of vs2 op vs1
  function automatic logic mask_op_bit(input logic [5:0] funct6, input logic a, input logic b);
    case (funct6)
      VMANDN:  return a & ~b;
      VMAND:   return a & b;
      VMOR:    return a | b;
      VMXOR:   return a ^ b;
      VMORN:   return a | ~b;
      VMNAND:  return ~(a & b);
      VMNOR:   return ~(a | b);
      default: return ~(a ^ b);
    endcase
  endfunction

  // prestart bits keep the old vd value
  function automatic logic [vlen-1:0] expected_result(input logic [5:0] funct6,
      input logic [vstart_width-1:0] vstart, input logic [vlen-1:0] vs2,
      input logic [vlen-1:0] vs1, input logic [vlen-1:0] vd);
    logic [vlen-1:0] res;
    for (int i = 0; i < vlen; i++) begin
      res[i] = (i < int'(vstart)) ? vd[i] : mask_op_bit(funct6, vs2[i], vs1[i]);
    end
    return res;
  endfunction

  function automatic logic [vlen-1:0] random_vector();
    logic [vlen-1:0] v;
    for (int i = 0; i < vlen / 32; i++) begin
      v[i*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  function automatic logic [vstart_width-1:0] nonzero_vstart();
    return vstart_width'(1 + ($urandom % (vlen - 1)));
  endfunction

  // queue occupancy once the coming rising edge has passed
  function automatic int predicted_occupancy();
    return outstanding + int'(uop_valid) - int'(result_valid);
  endfunction

  task automatic send_uop(input exe_funct3_e funct3, input logic [5:0] funct6,
      input logic [vstart_width-1:0] vstart, input logic [vlen-1:0] vs1,
      input logic [vlen-1:0] vs2, input logic [vlen-1:0] vd,
      input logic [rob_depth_width-1:0] rob_entry);
    int waited;
    waited = 0;
    // a uop driven at the next edge meets the rs_full of the cycle after it
    @(negedge clk);
    while (predicted_occupancy() >= rs_depth && waited < timeout_cycles) begin
      @(posedge clk);
      uop_valid <= 1'b0;
      @(negedge clk);
      waited++;
    end
    if (predicted_occupancy() >= rs_depth) begin
      run_failed("rs_full stayed high, dispatch could not continue");
    end
    @(posedge clk);
    uop_valid     <= 1'b1;
    uop_rob_entry <= rob_entry;
    uop_funct3    <= funct3;
    uop_funct6    <= funct6;
    uop_vstart    <= vstart;
    uop_vs1_data  <= vs1;
    uop_vs2_data  <= vs2;
    uop_vd_data   <= vd;
  endtask

  task automatic dispatch_random(input bit with_vstart);
    exe_funct3_e funct3;
    funct3 = ($urandom % 2 == 0) ? OPMVV : OPMVX;
    send_uop(funct3, op_list[$urandom % 8], with_vstart ? nonzero_vstart() : '0,
             random_vector(), random_vector(), random_vector(),
             rob_depth_width'($urandom));
  endtask

  task automatic go_idle();
    @(posedge clk);
    uop_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (outstanding != 0 && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (outstanding != 0) begin
      run_failed("uops still waiting for result_valid after the timeout");
    end
  endtask

  // results are checked before this edge's push is recorded
  always @(posedge clk) begin
    if (reset) begin
      exp_rob.delete();
      exp_data.delete();
      outstanding <= 0;
    end else begin
      a_full_level: assert (rs_full === (outstanding == rs_depth))
        else value_mismatch("rs_full", vlen'(outstanding == rs_depth), vlen'(rs_full));
      if (result_valid) begin
        a_result_owed: assert (exp_rob.size() > 0)
          else run_failed("result_valid rose with no uop outstanding");
        head_rob  = exp_rob.pop_front();
        head_data = exp_data.pop_front();
        results_seen++;
        a_rob_entry: assert (result_rob_entry === head_rob)
          else value_mismatch("result_rob_entry", vlen'(head_rob), vlen'(result_rob_entry));
        a_data: assert (result_data === head_data)
          else value_mismatch("result_data", head_data, result_data);
      end
      if (uop_valid) begin
        exp_rob.push_back(uop_rob_entry);
        exp_data.push_back(expected_result(uop_funct6, uop_vstart, uop_vs2_data,
                                           uop_vs1_data, uop_vd_data));
        uops_sent++;
      end
      outstanding <= outstanding + int'(uop_valid) - int'(result_valid);
    end
  end

  a_dispatch_hold: assert property (@(posedge clk) disable iff (reset)
    rs_full |-> !uop_valid)
    else run_failed("uop_valid was raised while rs_full was high");

  initial begin
    int k;
    int gap;
    void'($urandom(32'h524a7654));
    uops_sent     = 0;
    results_seen  = 0;
    reset         = 1'b1;
    uop_valid     = 1'b0;
    uop_rob_entry = '0;
    uop_funct3    = OPMVV;
    uop_funct6    = '0;
    uop_vstart    = '0;
    uop_vm        = 1'b1;
    uop_vd_data   = '0;
    uop_vd_valid  = 1'b1;
    uop_vs1_data  = '0;
    uop_vs1_valid = 1'b1;
    uop_vs2_data  = '0;
    uop_vs2_valid = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    @(negedge clk);
    a_idle_valid: assert (result_valid == 1'b0)
      else value_mismatch("result_valid", '0, vlen'(result_valid));
    a_idle_full: assert (rs_full == 1'b0)
      else value_mismatch("rs_full", '0, vlen'(rs_full));

    // lone uop on an empty queue comes out one cycle after acceptance
    send_uop(OPMVV, VMAND, '0, random_vector(), random_vector(), random_vector(), 3'd1);
    go_idle();
    @(negedge clk);
    a_first_result: assert (result_valid == 1'b1)
      else value_mismatch("result_valid", vlen'(1), vlen'(result_valid));
    wait_drain();

    // every op with vstart at 0
    for (k = 0; k < 8; k++) begin
      send_uop(OPMVV, op_list[k], '0, random_vector(), random_vector(), random_vector(),
               rob_depth_width'(k));
    end
    go_idle();
    wait_drain();

    // random prestart region with idle gaps
    for (k = 0; k < 24; k++) begin
      dispatch_random(1'b1);
      gap = $urandom % 3;
      repeat (gap) go_idle();
    end
    go_idle();
    wait_drain();

    // back-to-back burst
    for (k = 0; k < 32; k++) begin
      dispatch_random(k % 2 == 1);
    end
    go_idle();
    wait_drain();

    a_one_result_each: assert (results_seen == uops_sent)
      else value_mismatch("result count", vlen'(uops_sent), vlen'(results_seen));
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== hdl/rvv_backend_alu.sv ====
`timescale 1ns/1ps

module rvv_backend_alu
  import rvv_backend_pkg::*;
#(
  parameter int vlen            = 128,
  parameter int rob_depth_width = 3,
  parameter int rs_depth        = 4,
  localparam int vstart_width   = $clog2(vlen)
) (
  input  logic                       clk,
  input  logic                       reset,

  // dispatch
  input  logic                       uop_valid,
  output logic                       rs_full,
  input  logic [rob_depth_width-1:0] uop_rob_entry,
  input  exe_funct3_e                uop_funct3,
  input  logic [5:0]                 uop_funct6,
  input  logic [vstart_width-1:0]    uop_vstart,
  input  logic                       uop_vm,
  input  logic [vlen-1:0]            uop_vd_data,
  input  logic                       uop_vd_valid,
  input  logic [vlen-1:0]            uop_vs1_data,
  input  logic                       uop_vs1_valid,
  input  logic [vlen-1:0]            uop_vs2_data,
  input  logic                       uop_vs2_valid,

  // ROB writeback
  output logic                       result_valid,
  output logic [rob_depth_width-1:0] result_rob_entry,
  output logic [vlen-1:0]            result_data
);

  // queue head to ALU
  logic                       issue_valid;
  logic [rob_depth_width-1:0] issue_rob_entry;
  exe_funct3_e                issue_funct3;
  logic [5:0]                 issue_funct6;
  logic [vstart_width-1:0]    issue_vstart;
  logic                       issue_vm;
  logic [vlen-1:0]            issue_vd_data;
  logic                       issue_vd_valid;
  logic [vlen-1:0]            issue_vs1_data;
  logic                       issue_vs1_valid;
  logic [vlen-1:0]            issue_vs2_data;
  logic                       issue_vs2_valid;

  rvv_backend_alu_rs #(
    .vlen            (vlen),
    .rob_depth_width (rob_depth_width),
    .rs_depth        (rs_depth)
  ) alu_rs0 (
    .clk             (clk),
    .reset           (reset),
    .uop_valid       (uop_valid),
    .rs_full         (rs_full),
    .uop_rob_entry   (uop_rob_entry),
    .uop_funct3      (uop_funct3),
    .uop_funct6      (uop_funct6),
    .uop_vstart      (uop_vstart),
    .uop_vm          (uop_vm),
    .uop_vd_data     (uop_vd_data),
    .uop_vd_valid    (uop_vd_valid),
    .uop_vs1_data    (uop_vs1_data),
    .uop_vs1_valid   (uop_vs1_valid),
    .uop_vs2_data    (uop_vs2_data),
    .uop_vs2_valid   (uop_vs2_valid),
    .issue_valid     (issue_valid),
    .issue_rob_entry (issue_rob_entry),
    .issue_funct3    (issue_funct3),
    .issue_funct6    (issue_funct6),
    .issue_vstart    (issue_vstart),
    .issue_vm        (issue_vm),
    .issue_vd_data   (issue_vd_data),
    .issue_vd_valid  (issue_vd_valid),
    .issue_vs1_data  (issue_vs1_data),
    .issue_vs1_valid (issue_vs1_valid),
    .issue_vs2_data  (issue_vs2_data),
    .issue_vs2_valid (issue_vs2_valid)
  );

  // single-cycle execute, result leaves in the issue cycle
  rvv_backend_alu_unit #(
    .vlen             (vlen),
    .rob_depth_width  (rob_depth_width)
  ) alu_unit0 (
    .issue_valid      (issue_valid),
    .issue_rob_entry  (issue_rob_entry),
    .issue_funct3     (issue_funct3),
    .issue_funct6     (issue_funct6),
    .issue_vstart     (issue_vstart),
    .issue_vm         (issue_vm),
    .issue_vd_data    (issue_vd_data),
    .issue_vd_valid   (issue_vd_valid),
    .issue_vs1_data   (issue_vs1_data),
    .issue_vs1_valid  (issue_vs1_valid),
    .issue_vs2_data   (issue_vs2_data),
    .issue_vs2_valid  (issue_vs2_valid),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

// ==== hdl/rvv_backend_alu_unit.sv ====
`timescale 1ns/1ps

module rvv_backend_alu_unit
  import rvv_backend_pkg::*;
#(
  parameter int vlen            = 128,
  parameter int rob_depth_width = 3,
  localparam int vstart_width   = $clog2(vlen)
) (
  // uop from the reservation queue
  input  logic                       issue_valid,
  input  logic [rob_depth_width-1:0] issue_rob_entry,
  input  exe_funct3_e                issue_funct3,
  input  logic [5:0]                 issue_funct6,
  input  logic [vstart_width-1:0]    issue_vstart,
  input  logic                       issue_vm,
  input  logic [vlen-1:0]            issue_vd_data,
  input  logic                       issue_vd_valid,
  input  logic [vlen-1:0]            issue_vs1_data,
  input  logic                       issue_vs1_valid,
  input  logic [vlen-1:0]            issue_vs2_data,
  input  logic                       issue_vs2_valid,

  // writeback toward the ROB
  output logic                       result_valid,
  output logic [rob_depth_width-1:0] result_rob_entry,
  output logic [vlen-1:0]            result_data
);

  logic            is_opm;
  logic            opm_supported;
  logic            operands_ok;
  logic            exe_valid;
  logic [vlen-1:0] src2_data;
  logic [vlen-1:0] src1_data;
  logic [vlen-1:0] mask_result;
  logic [vlen-1:0] prestart;

  // bitwise mask-register logic, vs2 op vs1
  function automatic logic [vlen-1:0] f_mask_logic(
    input logic [5:0]      funct6,
    input logic [vlen-1:0] vs2,
    input logic [vlen-1:0] vs1
  );
    logic [vlen-1:0] res;
    res = '0;
    case (funct6)
      VMANDN:  res = vs2 & ~vs1;
      VMAND:   res = vs2 & vs1;
      VMOR:    res = vs2 | vs1;
      VMXOR:   res = vs2 ^ vs1;
      VMORN:   res = vs2 | ~vs1;
      VMNAND:  res = ~(vs2 & vs1);
      VMNOR:   res = ~(vs2 | vs1);
      VMXNOR:  res = ~(vs2 ^ vs1);
      default: res = '0;
    endcase
    return res;
  endfunction

  // decode
  always_comb begin
    is_opm        = 1'b0;
    opm_supported = 1'b0;
    case (issue_funct3)
      OPMVV,
      OPMVX: begin
        is_opm = 1'b1;
        case (issue_funct6)
          VMANDN,
          VMAND,
          VMOR,
          VMXOR,
          VMORN,
          VMNAND,
          VMNOR,
          VMXNOR: opm_supported = 1'b1;
          default: opm_supported = 1'b0;
        endcase
      end
      // OPI arithmetic is not implemented here
      default: begin
        is_opm        = 1'b0;
        opm_supported = 1'b0;
      end
    endcase
  end

  // mask ops are never masked by v0, so vm must be set
  assign operands_ok = issue_vs1_valid & issue_vs2_valid & issue_vd_valid & issue_vm;
  assign exe_valid   = issue_valid & opm_supported & operands_ok;

  // keep the logic quiet when nothing useful is issued
  assign src2_data = exe_valid ? issue_vs2_data : '0;
  assign src1_data = exe_valid ? issue_vs1_data : '0;

  assign mask_result = f_mask_logic(issue_funct6, src2_data, src1_data);

  // bits below vstart are not written
  always_comb begin
    prestart = '0;
    for (int i = 0; i < vlen; i++) begin
      prestart[i] = (i < issue_vstart);
    end
  end

  assign result_data      = (issue_vd_data & prestart) | (mask_result & ~prestart);
  assign result_rob_entry = issue_rob_entry;
  assign result_valid     = exe_valid;

  // no clock reaches this unit, so the checks run on the issue inputs
  always_comb begin
    if (issue_valid) begin
      a_opm_category: assert (is_opm)
        else $error("alu unit: rob_entry=%0d unsupported funct3 %s",
                    issue_rob_entry, issue_funct3.name());
      if (is_opm) begin
        a_opm_funct6: assert (opm_supported)
          else $error("alu unit: rob_entry=%0d unsupported opm funct6 %b",
                      issue_rob_entry, issue_funct6);
      end
      if (opm_supported) begin
        a_operands: assert (operands_ok)
          else $error("alu unit: rob_entry=%0d vs1(%0b) vs2(%0b) vd(%0b) vm(%0b) should all be 1",
                      issue_rob_entry, issue_vs1_valid, issue_vs2_valid,
                      issue_vd_valid, issue_vm);
      end
    end
  end

endmodule

// ==== hdl/rvv_backend_alu_rs.sv ====
`timescale 1ns/1ps

module rvv_backend_alu_rs
  import rvv_backend_pkg::*;
#(
  parameter int vlen            = 128,
  parameter int rob_depth_width = 3,
  parameter int rs_depth        = 4,
  localparam int vstart_width   = $clog2(vlen)
) (
  input  logic                       clk,
  input  logic                       reset,

  // dispatch side
  input  logic                       uop_valid,
  output logic                       rs_full,
  input  logic [rob_depth_width-1:0] uop_rob_entry,
  input  exe_funct3_e                uop_funct3,
  input  logic [5:0]                 uop_funct6,
  input  logic [vstart_width-1:0]    uop_vstart,
  input  logic                       uop_vm,
  input  logic [vlen-1:0]            uop_vd_data,
  input  logic                       uop_vd_valid,
  input  logic [vlen-1:0]            uop_vs1_data,
  input  logic                       uop_vs1_valid,
  input  logic [vlen-1:0]            uop_vs2_data,
  input  logic                       uop_vs2_valid,

  // head of queue toward the ALU
  output logic                       issue_valid,
  output logic [rob_depth_width-1:0] issue_rob_entry,
  output exe_funct3_e                issue_funct3,
  output logic [5:0]                 issue_funct6,
  output logic [vstart_width-1:0]    issue_vstart,
  output logic                       issue_vm,
  output logic [vlen-1:0]            issue_vd_data,
  output logic                       issue_vd_valid,
  output logic [vlen-1:0]            issue_vs1_data,
  output logic                       issue_vs1_valid,
  output logic [vlen-1:0]            issue_vs2_data,
  output logic                       issue_vs2_valid
);

  localparam int ptr_width = (rs_depth > 1) ? $clog2(rs_depth) : 1;
  localparam int cnt_width = $clog2(rs_depth + 1);

  // entry storage, one array per field
  logic [rob_depth_width-1:0] rob_entry_q [rs_depth];
  exe_funct3_e                funct3_q    [rs_depth];
  logic [5:0]                 funct6_q    [rs_depth];
  logic [vstart_width-1:0]    vstart_q    [rs_depth];
  logic                       vm_q        [rs_depth];
  logic [vlen-1:0]            vd_data_q   [rs_depth];
  logic                       vd_valid_q  [rs_depth];
  logic [vlen-1:0]            vs1_data_q  [rs_depth];
  logic                       vs1_valid_q [rs_depth];
  logic [vlen-1:0]            vs2_data_q  [rs_depth];
  logic                       vs2_valid_q [rs_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 push;
  logic                 pop;

  // wrap at rs_depth, depth need not be a power of two
  function automatic logic [ptr_width-1:0] ptr_inc(input logic [ptr_width-1:0] ptr);
    if (ptr == ptr_width'(rs_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rs_full     = (count == cnt_width'(rs_depth));
  assign issue_valid = (count != '0);
  // the ALU never stalls, so the head leaves every cycle it is valid
  assign pop         = issue_valid;
  assign push        = uop_valid & ~rs_full;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rob_entry_q[wr_ptr] <= uop_rob_entry;
      funct3_q[wr_ptr]    <= uop_funct3;
      funct6_q[wr_ptr]    <= uop_funct6;
      vstart_q[wr_ptr]    <= uop_vstart;
      vm_q[wr_ptr]        <= uop_vm;
      vd_data_q[wr_ptr]   <= uop_vd_data;
      vd_valid_q[wr_ptr]  <= uop_vd_valid;
      vs1_data_q[wr_ptr]  <= uop_vs1_data;
      vs1_valid_q[wr_ptr] <= uop_vs1_valid;
      vs2_data_q[wr_ptr]  <= uop_vs2_data;
      vs2_valid_q[wr_ptr] <= uop_vs2_valid;
    end
  end

  // head entry straight from storage
  assign issue_rob_entry = rob_entry_q[rd_ptr];
  assign issue_funct3    = funct3_q[rd_ptr];
  assign issue_funct6    = funct6_q[rd_ptr];
  assign issue_vstart    = vstart_q[rd_ptr];
  assign issue_vm        = vm_q[rd_ptr];
  assign issue_vd_data   = vd_data_q[rd_ptr];
  assign issue_vd_valid  = vd_valid_q[rd_ptr];
  assign issue_vs1_data  = vs1_data_q[rd_ptr];
  assign issue_vs1_valid = vs1_valid_q[rd_ptr];
  assign issue_vs2_data  = vs2_data_q[rd_ptr];
  assign issue_vs2_valid = vs2_valid_q[rd_ptr];

  // dispatch must hold off while the queue reports full
  a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    rs_full |-> !uop_valid)
    else $error("alu rs: uop_valid raised while rs_full is high");

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= cnt_width'(rs_depth))
    else $error("alu rs: occupancy %0d above rs_depth %0d", count, rs_depth);

endmodule

// ==== hdl/rvv_backend_pkg.sv ====
package rvv_backend_pkg;

  // operation category, the funct3 field of OP-V instructions
  // OPF categories are not part of this backend
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } exe_funct3_e;

  // OPM funct6 codes for the mask-register logical group
  // all of them sit in the 0110xx / 0111xx block of the opcode map
  typedef enum logic [5:0] {
    // vd = vs2 & ~vs1
    VMANDN = 6'b011000,
    // vd = vs2 & vs1
    VMAND  = 6'b011001,
    // vd = vs2 | vs1
    VMOR   = 6'b011010,
    // vd = vs2 ^ vs1
    VMXOR  = 6'b011011,
    // vd = vs2 | ~vs1
    VMORN  = 6'b011100,
    // vd = ~(vs2 & vs1)
    VMNAND = 6'b011101,
    // vd = ~(vs2 | vs1)
    VMNOR  = 6'b011110,
    // vd = ~(vs2 ^ vs1)
    VMXNOR = 6'b011111
  } opm_funct6_e;

endpackage
